/* meso_pkg.sv */
// mesosync channel constants
package meso_pkg;

    // channel word width in bits
    localparam int WIDTH = 16;

    // input fifo depth
    // the far sender never has more credits in flight than this
    localparam int ELS = 4;

    // free far-end slots assumed right after reset
    // keep at or below the far fifo depth
    localparam int CREDIT_INITIAL = 4;

    // ceiling for both credit counters
    localparam int CREDIT_MAX = 15;

    // credits carried by one token pulse
    localparam int DECIMATION = 2;

    // bit positions in the mode write word
    localparam int MODE_LINE_READY_BIT = 0;
    localparam int MODE_LOOPBACK_BIT   = 1;

endpackage

/* relay_fifo.sv */
// two-entry relay stage
`timescale 1ns/1ps

module relay_fifo #(
    parameter int width_p = meso_pkg::WIDTH
) (
      input  logic               clk_i
    , input  logic               rst_n_i

    , input  logic               v_i
    , input  logic [width_p-1:0] data_i
    , output logic               ready_o

    , output logic               v_o
    , output logic [width_p-1:0] data_o
    , input  logic               ready_i
);

    // main entry feeds the output, skid entry catches the word in flight
    logic               main_v_r, skid_v_r;
    logic [width_p-1:0] main_data_r, skid_data_r;
    logic               in_fire, main_free;

    // ready comes straight off the skid flop
    assign ready_o   = ~skid_v_r;
    assign in_fire   = v_i & ready_o;
    // main can take a word when empty or draining this cycle
    assign main_free = ~main_v_r | ready_i;

    assign v_o    = main_v_r;
    assign data_o = main_data_r;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            main_v_r <= 1'b0;
            skid_v_r <= 1'b0;
        end else begin
            // skid has priority over the input to keep order
            if (main_free)
                main_v_r <= skid_v_r | in_fire;
            if (skid_v_r & main_free)
                skid_v_r <= 1'b0;
            else if (in_fire & ~main_free)
                skid_v_r <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (main_free)
            main_data_r <= skid_v_r ? skid_data_r : data_i;
        // park the word when main is stalled
        if (in_fire & ~main_free)
            skid_data_r <= data_i;
    end

endmodule

/* credit_fifo.sv */
// credit-returning input fifo
`timescale 1ns/1ps

module credit_fifo #(
    parameter int width_p = meso_pkg::WIDTH,
    parameter int els_p   = meso_pkg::ELS
) (
      input  logic               clk_i
    , input  logic               rst_n_i

    // channel side has no back-pressure
    , input  logic               v_i
    , input  logic [width_p-1:0] data_i
    , output logic               credit_o

    // core side where yumi means the word is taken
    , output logic               v_o
    , output logic [width_p-1:0] data_o
    , input  logic               yumi_i
);

    localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
    localparam int cnt_w_lp = $clog2(els_p + 1);

    logic [width_p-1:0]  mem_r [els_p];
    logic [ptr_w_lp-1:0] wptr_r, rptr_r;
    logic [cnt_w_lp-1:0] count_r;
    logic                credit_r;

    // pointer step with wrap for any depth
    function automatic logic [ptr_w_lp-1:0] ptr_next(input logic [ptr_w_lp-1:0] p);
        if (p == ptr_w_lp'(els_p - 1))
            return '0;
        return p + ptr_w_lp'(1);
    endfunction

    assign v_o      = (count_r != '0);
    assign data_o   = mem_r[rptr_r];
    assign credit_o = credit_r;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wptr_r   <= '0;
            rptr_r   <= '0;
            count_r  <= '0;
            credit_r <= 1'b0;
        end else begin
            // sender holds a credit for every word so there is always room
            if (v_i)
                wptr_r <= ptr_next(wptr_r);
            if (yumi_i)
                rptr_r <= ptr_next(rptr_r);
            count_r  <= count_r + cnt_w_lp'(v_i) - cnt_w_lp'(yumi_i);
            // one credit back per released slot on the next cycle
            credit_r <= yumi_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (v_i)
            mem_r[wptr_r] <= data_i;
    end

endmodule

/* credit_to_token.sv */
// credit to token decimator
`timescale 1ns/1ps

module credit_to_token #(
    parameter int decimation_p     = meso_pkg::DECIMATION,
    parameter int credit_max_val_p = meso_pkg::CREDIT_MAX
) (
      input  logic clk_i
    , input  logic rst_n_i
    , input  logic credit_i
    , input  logic line_ready_i
    , output logic token_o
);

    localparam int cnt_w_lp = $clog2(credit_max_val_p + 1);
    localparam int sum_w_lp = cnt_w_lp + 1;

    logic [cnt_w_lp-1:0] count_r;
    logic [sum_w_lp-1:0] sum;
    logic                emit, token_r;

    // enough credits banked and the link can carry a token
    assign emit    = line_ready_i & ({1'b0, count_r} >= sum_w_lp'(decimation_p));
    assign token_o = token_r;

    always_comb begin
        sum = {1'b0, count_r} + sum_w_lp'(credit_i);
        // spend a token's worth on the same edge it is sent
        if (emit)
            sum = sum - sum_w_lp'(decimation_p);
        if (sum > sum_w_lp'(credit_max_val_p))
            sum = sum_w_lp'(credit_max_val_p);
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_r <= '0;
            token_r <= 1'b0;
        end else begin
            count_r <= sum[cnt_w_lp-1:0];
            token_r <= emit;
        end
    end

endmodule

/* token_credit_counter.sv */
// output credit counter
`timescale 1ns/1ps

module token_credit_counter #(
    parameter int credit_initial_p = meso_pkg::CREDIT_INITIAL,
    parameter int credit_max_val_p = meso_pkg::CREDIT_MAX,
    parameter int decimation_p     = meso_pkg::DECIMATION
) (
      input  logic clk_i
    , input  logic rst_n_i

    // upstream valid/ready
    , input  logic v_i
    , output logic ready_o

    // channel strobe and returning token
    , output logic v_o
    , input  logic token_i
);

    localparam int cnt_w_lp = $clog2(credit_max_val_p + 1);
    localparam int sum_w_lp = cnt_w_lp + 1;

    // free slots in the far fifo
    logic [cnt_w_lp-1:0] count_r;
    logic [sum_w_lp-1:0] next;

    assign ready_o = (count_r != '0);
    // each strobe spends one credit
    assign v_o     = v_i & ready_o;

    always_comb begin
        next = {1'b0, count_r};
        if (v_o)
            next = next - sum_w_lp'(1);
        // token refills a fixed batch
        if (token_i)
            next = next + sum_w_lp'(decimation_p);
        if (next > sum_w_lp'(credit_max_val_p))
            next = sum_w_lp'(credit_max_val_p);
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i)
            count_r <= cnt_w_lp'(credit_initial_p);
        else
            count_r <= next[cnt_w_lp-1:0];
    end

endmodule

/* meso_mode_regs.sv */
// channel mode registers
`timescale 1ns/1ps

module meso_mode_regs (
      input  logic       clk_i
    , input  logic       rst_n_i

    // single-cycle write of both mode bits
    , input  logic       cfg_we_i
    , input  logic [1:0] cfg_wdata_i

    , output logic       line_ready_o
    , output logic       loopback_en_o
);

    logic line_ready_r, loopback_r;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            line_ready_r <= 1'b0;
            loopback_r   <= 1'b0;
        end else if (cfg_we_i) begin
            line_ready_r <= cfg_wdata_i[meso_pkg::MODE_LINE_READY_BIT];
            loopback_r   <= cfg_wdata_i[meso_pkg::MODE_LOOPBACK_BIT];
        end
    end

    // new mode visible the cycle after the strobe
    assign line_ready_o  = line_ready_r;
    assign loopback_en_o = loopback_r;

endmodule

/* meso_core.sv */
// mesosync channel core side
`timescale 1ns/1ps

module meso_core #(
    parameter int width_p          = meso_pkg::WIDTH,
    parameter int els_p            = meso_pkg::ELS,
    parameter int credit_initial_p = meso_pkg::CREDIT_INITIAL,
    parameter int credit_max_val_p = meso_pkg::CREDIT_MAX,
    parameter int decimation_p     = meso_pkg::DECIMATION
) (
      input  logic               clk_i
    , input  logic               rst_n_i

    // channel in and token back
    , input  logic [width_p-1:0] meso_data_i
    , input  logic               meso_v_i
    , output logic               meso_token_o

    // channel out and token in
    , output logic               meso_v_o
    , output logic [width_p-1:0] meso_data_o
    , input  logic               meso_token_i

    // core in
    , input  logic               v_i
    , input  logic [width_p-1:0] data_i
    , output logic               ready_o

    // core out
    , output logic               v_o
    , output logic [width_p-1:0] data_o
    , input  logic               ready_i

    // mode write
    , input  logic               cfg_we_i
    , input  logic [1:0]         cfg_wdata_i
);

    logic               line_ready, loopback_en;
    logic               in_relay_ready, in_relay_v, in_relay_ready_i;
    logic [width_p-1:0] in_relay_data;
    logic               out_relay_v_i, out_relay_ready;
    logic               fifo_v, fifo_yumi, fifo_credit;
    logic [width_p-1:0] fifo_data;
    logic               send_v, fifo_ready_sel;
    logic               cnt_v_i, cnt_ready, gated_ready;

    meso_mode_regs mode_regs (
          .clk_i         (clk_i)
        , .rst_n_i       (rst_n_i)
        , .cfg_we_i      (cfg_we_i)
        , .cfg_wdata_i   (cfg_wdata_i)
        , .line_ready_o  (line_ready)
        , .loopback_en_o (loopback_en)
    );

    // core is shut out entirely during loopback
    assign ready_o = in_relay_ready & ~loopback_en;

    relay_fifo #(.width_p(width_p)) input_relay (
          .clk_i   (clk_i)
        , .rst_n_i (rst_n_i)
        , .v_i     (v_i & ~loopback_en)
        , .data_i  (data_i)
        , .ready_o (in_relay_ready)
        , .v_o     (in_relay_v)
        , .data_o  (in_relay_data)
        , .ready_i (in_relay_ready_i)
    );

    relay_fifo #(.width_p(width_p)) output_relay (
          .clk_i   (clk_i)
        , .rst_n_i (rst_n_i)
        , .v_i     (out_relay_v_i)
        , .data_i  (fifo_data)
        , .ready_o (out_relay_ready)
        , .v_o     (v_o)
        , .data_o  (data_o)
        , .ready_i (ready_i)
    );

    // loopback source is the input fifo, otherwise the core relay
    assign send_v           = loopback_en ? fifo_v    : in_relay_v;
    assign meso_data_o      = loopback_en ? fifo_data : in_relay_data;
    assign fifo_ready_sel   = loopback_en ? gated_ready : out_relay_ready;
    assign out_relay_v_i    = ~loopback_en & fifo_v;
    assign in_relay_ready_i = ~loopback_en & gated_ready;

    // nothing leaves before the line is up
    assign cnt_v_i     = line_ready & send_v;
    assign gated_ready = line_ready & cnt_ready;

    // ready to yumi
    assign fifo_yumi = fifo_ready_sel & fifo_v;

    credit_fifo #(.width_p(width_p), .els_p(els_p)) input_fifo (
          .clk_i    (clk_i)
        , .rst_n_i  (rst_n_i)
        , .v_i      (meso_v_i)
        , .data_i   (meso_data_i)
        , .credit_o (fifo_credit)
        , .v_o      (fifo_v)
        , .data_o   (fifo_data)
        , .yumi_i   (fifo_yumi)
    );

    credit_to_token #(
          .decimation_p     (decimation_p)
        , .credit_max_val_p (credit_max_val_p)
    ) token_gen (
          .clk_i        (clk_i)
        , .rst_n_i      (rst_n_i)
        , .credit_i     (fifo_credit)
        , .line_ready_i (line_ready)
        , .token_o      (meso_token_o)
    );

    token_credit_counter #(
          .credit_initial_p (credit_initial_p)
        , .credit_max_val_p (credit_max_val_p)
        , .decimation_p     (decimation_p)
    ) out_credits (
          .clk_i   (clk_i)
        , .rst_n_i (rst_n_i)
        , .v_i     (cnt_v_i)
        , .ready_o (cnt_ready)
        , .v_o     (meso_v_o)
        , .token_i (meso_token_i)
    );

endmodule

/* tb_meso_core.sv */
// mesosync channel testbench
`timescale 1ns/1ps

module tb_meso_core;

    localparam int width_lp = meso_pkg::WIDTH;
    localparam int dec_lp   = meso_pkg::DECIMATION;
    localparam int init_lp  = meso_pkg::CREDIT_INITIAL;

    logic                clk_i = 1'b0;
    logic                rst_n_i = 1'b0;
    logic [width_lp-1:0] meso_data_i = '0;
    logic                meso_v_i = 1'b0;
    logic                meso_token_i = 1'b0;
    logic                v_i = 1'b0;
    logic [width_lp-1:0] data_i = '0;
    logic                ready_i = 1'b1;
    logic                cfg_we_i = 1'b0;
    logic [1:0]          cfg_wdata_i = 2'b00;
    logic                meso_token_o, meso_v_o, ready_o, v_o;
    logic [width_lp-1:0] meso_data_o, data_o;

    // expected words per direction
    logic [width_lp-1:0] exp_chan_q[$];
    logic [width_lp-1:0] exp_core_q[$];

    // stimulus targets come from the test sequence and the model keeps the progress
    int core_target = 0, core_sent = 0, chan_target = 0, chan_sent = 0;
    int core_rx = 0, chan_rx = 0, tokens_seen = 0, tokens_owed = 0, tokens_back = 0;
    int far_credits = meso_pkg::ELS;
    int token_delay = 0, quiet_hits = 0, lb_v_hits = 0;
    int bg_errs = 0, main_errs = 0, tests_run = 0, tests_failed = 0;
    bit lb_mode = 1'b0, rand_ready = 1'b0, quiet = 1'b0, aborted = 1'b0, core_took;
    logic [15:0] lfsr_r = 16'd77;

    meso_core #(
          .width_p          (width_lp)
        , .els_p            (meso_pkg::ELS)
        , .credit_initial_p (meso_pkg::CREDIT_INITIAL)
        , .credit_max_val_p (meso_pkg::CREDIT_MAX)
        , .decimation_p     (meso_pkg::DECIMATION)
    ) u_dut (
          .clk_i        (clk_i)
        , .rst_n_i      (rst_n_i)
        , .meso_data_i  (meso_data_i)
        , .meso_v_i     (meso_v_i)
        , .meso_token_o (meso_token_o)
        , .meso_v_o     (meso_v_o)
        , .meso_data_o  (meso_data_o)
        , .meso_token_i (meso_token_i)
        , .v_i          (v_i)
        , .data_i       (data_i)
        , .ready_o      (ready_o)
        , .v_o          (v_o)
        , .data_o       (data_o)
        , .ready_i      (ready_i)
        , .cfg_we_i     (cfg_we_i)
        , .cfg_wdata_i  (cfg_wdata_i)
    );

    always #4 clk_i = ~clk_i;

    // fibonacci lfsr with taps 16 14 13 11 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_r[15] ^ lfsr_r[13] ^ lfsr_r[12] ^ lfsr_r[10];
            lfsr_r = {lfsr_r[14:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act, inout int errs);
        if (exp !== act) begin
            $display("Fail %s: expected %0h actual %0h", name, exp, act);
            errs++;
        end
    endtask

    // far-end link model and core-side agents sample at the edge and drive 1 ns later
    always begin
        @(posedge clk_i);
        if (meso_token_o) begin
            far_credits += dec_lp;
            tokens_seen++;
        end
        if (quiet && (meso_v_o || meso_token_o))
            quiet_hits++;
        if (lb_mode && v_o)
            lb_v_hits++;
        core_took = v_i && ready_o;
        if (core_took) begin
            exp_chan_q.push_back(data_i);
            core_sent++;
        end
        if (v_o && ready_i) begin
            if (exp_core_q.size() == 0) begin
                $display("word %0h on data_o with none expected", data_o);
                bg_errs++;
            end else
                check_val("chan_to_core", 32'(exp_core_q.pop_front()), 32'(data_o), bg_errs);
            core_rx++;
        end
        if (meso_v_o) begin
            if (exp_chan_q.size() == 0) begin
                $display("word %0h on meso_data_o with none expected", meso_data_o);
                bg_errs++;
            end else if (lb_mode)
                check_val("loopback", 32'(exp_chan_q.pop_front()), 32'(meso_data_o),
                          bg_errs);
            else
                check_val("core_to_chan", 32'(exp_chan_q.pop_front()), 32'(meso_data_o),
                          bg_errs);
            chan_rx++;
            // far fifo can never be overrun
            if (chan_rx - tokens_back * dec_lp > init_lp) begin
                $display("channel sent %0d words with only %0d credits granted",
                         chan_rx, init_lp + tokens_back * dec_lp);
                bg_errs++;
            end
            if (chan_rx % dec_lp == 0)
                tokens_owed++;
        end
        #1;
        // core in keeps v_i and data until taken
        if (core_took)
            v_i = 1'b0;
        if (!v_i && core_sent < core_target && rand_bits(1)) begin
            v_i    = 1'b1;
            data_i = width_lp'(rand_bits(width_lp));
        end
        // far sender only spends credits it holds
        meso_v_i = 1'b0;
        if (chan_sent < chan_target && far_credits > 0 && rand_bits(1)) begin
            meso_v_i    = 1'b1;
            meso_data_i = width_lp'(rand_bits(width_lp));
            far_credits--;
            chan_sent++;
            if (lb_mode)
                exp_chan_q.push_back(meso_data_i);
            else
                exp_core_q.push_back(meso_data_i);
        end
        ready_i = rand_ready ? (rand_bits(2) != 0) : 1'b1;
        // token return after a random gap
        meso_token_i = 1'b0;
        if (token_delay > 0)
            token_delay--;
        else if (tokens_back < tokens_owed) begin
            meso_token_i = 1'b1;
            tokens_back++;
            token_delay  = rand_bits(3);
        end
    end

    task automatic write_mode(input logic [1:0] bits);
        cfg_wdata_i = bits;
        cfg_we_i    = 1'b1;
        @(posedge clk_i);
        #1;
        cfg_we_i    = 1'b0;
    endtask

    // all stimulus accepted and every expected word seen
    task automatic wait_drained(input string what, input int limit);
        bit done;
        done = 1'b0;
        for (int n = 0; n < limit && !done; n++) begin
            @(posedge clk_i);
            done = core_sent == core_target && chan_sent == chan_target && !v_i
                && exp_chan_q.size() == 0 && exp_core_q.size() == 0;
        end
        #1;
        if (!done) begin
            $display("timeout: %s traffic did not drain within %0d cycles", what, limit);
            main_errs++;
            aborted = 1'b1;
        end
    endtask

    // link quiet and all owed tokens handed back
    task automatic wait_link_idle(input int limit);
        int idle;
        idle = 0;
        for (int n = 0; n < limit && idle < 32; n++) begin
            @(posedge clk_i);
            if (meso_token_o || meso_v_i || meso_v_o || tokens_back < tokens_owed)
                idle = 0;
            else
                idle++;
        end
        #1;
        if (idle < 32) begin
            $display("timeout: link did not go idle within %0d cycles", limit);
            main_errs++;
            aborted = 1'b1;
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        int errs;
        errs = main_errs + bg_errs - errs_at_start;
        tests_run++;
        if (errs == 0)
            $display("test %s: ok", name);
        else begin
            $display("test %s: %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    initial begin
        int e, base;
        repeat (16) @(posedge clk_i);
        #1 rst_n_i = 1'b1;

        e = main_errs + bg_errs;
        check_val("reset_meso_v_o", 0, 32'(meso_v_o), main_errs);
        check_val("reset_v_o", 0, 32'(v_o), main_errs);
        check_val("reset_meso_token_o", 0, 32'(meso_token_o), main_errs);
        check_val("reset_ready_o", 1, 32'(ready_o), main_errs);
        end_test("reset_state", e);

        e    = main_errs + bg_errs;
        base = chan_rx;
        write_mode(2'b01);
        core_target += 200;
        wait_drained("core_to_chan", 20000);
        check_val("core_to_chan_count", 200, chan_rx - base, main_errs);
        end_test("core_to_chan", e);

        if (!aborted) begin
            e          = main_errs + bg_errs;
            base       = core_rx;
            rand_ready = 1'b1;
            chan_target += 200;
            wait_drained("chan_to_core", 20000);
            rand_ready = 1'b0;
            check_val("chan_to_core_count", 200, core_rx - base, main_errs);
            end_test("chan_to_core", e);
        end

        if (!aborted) begin
            e = main_errs + bg_errs;
            wait_link_idle(2000);
            check_val("token_count", core_rx / dec_lp, tokens_seen, main_errs);
            end_test("token_count", e);
        end

        if (!aborted) begin
            // line down holds off both channel words and tokens
            // while returned credits bank up from channel words sent to the core
            e    = main_errs + bg_errs;
            base = chan_rx;
            write_mode(2'b00);
            quiet = 1'b1;
            core_target += 20;
            chan_target += meso_pkg::ELS;
            repeat (100) @(posedge clk_i);
            #1;
            quiet = 1'b0;
            check_val("line_down_quiet", 0, quiet_hits, main_errs);
            write_mode(2'b01);
            wait_drained("line_down", 5000);
            check_val("line_down_count", 20, chan_rx - base, main_errs);
            if (!aborted) begin
                wait_link_idle(2000);
                check_val("line_down_tokens", core_rx / dec_lp, tokens_seen, main_errs);
            end
            end_test("line_not_ready", e);
        end

        if (!aborted) begin
            e    = main_errs + bg_errs;
            base = chan_rx;
            write_mode(2'b11);
            lb_mode = 1'b1;
            chan_target += 100;
            wait_drained("loopback", 10000);
            check_val("loopback_count", 100, chan_rx - base, main_errs);
            check_val("loopback_v_o", 0, lb_v_hits, main_errs);
            end_test("loopback", e);
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 main_errs + bg_errs);
        if (main_errs + bg_errs == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* sim.f */
meso_pkg.sv
relay_fifo.sv
credit_fifo.sv
credit_to_token.sv
token_credit_counter.sv
meso_mode_regs.sv
meso_core.sv
tb_meso_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mesosync channel testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -f sim.f --top-module tb_meso_core \
    -o tb_meso_core > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$build_log"
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_meso_core > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$sim_log"; then
    exit 1
fi
exit 0
